// ==== common/nocPkg.sv ====
package nocPkg;

  localparam int numPorts = 5;

  typedef logic [2:0] flitIdT;

  localparam flitIdT idHeader = 3'd1;
  localparam flitIdT idBody   = 3'd2;
  localparam flitIdT idTail   = 3'd3;

  typedef logic [3:0]  coordT;
  typedef logic [11:0] lengthT;

  // One bit per port, in arbitration order
  typedef logic [4:0] portT;

  localparam portT dirLocal = 5'b00001;
  localparam portT dirNorth = 5'b00010;
  localparam portT dirEast  = 5'b00100;
  localparam portT dirWest  = 5'b01000;
  localparam portT dirSouth = 5'b10000;

  typedef struct packed {
    logic [7:0] reserved;
    logic [3:0] srcTag;
    coordT      destX;
    coordT      destY;
    lengthT     length;  // Counts every flit of the packet, header included
  } headerT;

  typedef struct packed {
    flitIdT      id;
    logic [31:0] data;
  } flitT;

  typedef enum logic [2:0] {
    idle  = 3'd0,
    holdL = 3'd1,
    holdN = 3'd2,
    holdE = 3'd3,
    holdW = 3'd4,
    holdS = 3'd5
  } arbStateT;

endpackage

// ==== hw/inputPort/inputPort.sv ====
`timescale 1ns/1ps

module inputPort
  import nocPkg::*;
#(
  parameter coordT localX    = 4'd0,
  parameter coordT localY    = 4'd0,
  parameter int    fifoDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  flitT inFlit,
  input  logic inValid,
  output logic inReady,
  input  logic pop,
  output flitT headFlit,
  output logic headValid,
  output portT routeReq
);

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntW = $clog2(fifoDepth + 1);

  flitT            mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            push;
  logic            doPop;
  headerT          headHdr;
  portT            routeCalc;
  portT            routeReg;
  logic            routeValid;
  logic            routeLoad;

  assign inReady   = (count != cntW'(fifoDepth));
  assign push      = inValid && inReady;
  assign headValid = (count != '0);
  assign doPop     = pop && headValid;
  assign headFlit  = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + cntW'(push) - cntW'(doPop);
    end
  end

  assign headHdr = headerT'(headFlit.data);

  // X first, then Y
  always_comb
  begin
    if (headHdr.destX > localX)
      routeCalc = dirEast;
    else if (headHdr.destX < localX)
      routeCalc = dirWest;
    else if (headHdr.destY > localY)
      routeCalc = dirNorth;
    else if (headHdr.destY < localY)
      routeCalc = dirSouth;
    else
      routeCalc = dirLocal;
  end

  assign routeLoad = headValid && !routeValid && (headFlit.id == idHeader);

  always_ff @(posedge clk)
  begin
    if (rst)
      routeValid <= 1'b0;
    else if (doPop && headFlit.id == idTail)
      routeValid <= 1'b0;  // Route is released with the tail
    else if (routeLoad)
      routeValid <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (routeLoad)
      routeReg <= routeCalc;
  end

  assign routeReq = (headValid && routeValid) ? routeReg : '0;

  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> headValid)
    else $error("inputPort popped while the FIFO is empty");

endmodule

// ==== hw/switchArbiter/packetTimer.sv ====
`timescale 1ns/1ps

module packetTimer
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  flitT headFlit,
  input  logic held,
  input  logic advance,
  output logic timesUp
);

  headerT hdr;
  lengthT count;
  lengthT limit;

  assign hdr = headerT'(headFlit.data);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      if (advance && headFlit.id == idHeader)
        limit <= hdr.length;
      if (!held)
        count <= '0;  // Restarts on every new or renewed grant
      else if (advance)
        count <= count + 1'b1;
    end
  end

  // A zero count never expires, so a stale limit cannot block a fresh holder
  assign timesUp = (count != '0) && (count == limit);

endmodule

// ==== hw/switchArbiter/switchArbiter.sv ====
`timescale 1ns/1ps

module switchArbiter
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  portT req,
  input  flitT headFlit [numPorts],
  input  logic outReady,
  output portT grant
);

  arbStateT   state;
  arbStateT   nextState;
  portT       holdVec;
  logic [2:0] holdIdx;
  portT       timesUp;
  portT       held;
  portT       advance;

  // First requester after port last, wrapping around to last itself
  function automatic arbStateT pickNext(portT reqs, logic [2:0] last);
    arbStateT    pick;
    int unsigned idx;
    pick = idle;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (int'(last) + k) % numPorts;
      if (reqs[idx])
        pick = arbStateT'(idx + 1);  // Nearest requester is written last
    end
    return pick;
  endfunction

  always_comb
  begin
    holdVec = '0;
    holdIdx = 3'(numPorts - 1);  // From idle the scan starts at Local
    if (state != idle)
    begin
      holdIdx = 3'(state) - 3'd1;
      holdVec[holdIdx] = 1'b1;
    end
  end

  always_comb
  begin
    if (state != idle && req[holdIdx] && !timesUp[holdIdx])
      nextState = state;
    else
      nextState = pickNext(req, holdIdx);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

  // An expired holder sits out one cycle while its count clears
  assign held    = holdVec & ~timesUp;
  assign grant   = held & req;
  assign advance = grant & req & {numPorts{outReady}};

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    packetTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[i]),
      .held     (held[i]),
      .advance  (advance[i]),
      .timesUp  (timesUp[i])
    );
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("switchArbiter grant is not one-hot");

  // The registered state may only move to an input that requested in the cycle before
  grantRiseReq: assert property (@(posedge clk) disable iff (rst)
    ((grant & ~$past(grant) & ~$past(req)) == '0))
    else $error("switchArbiter granted an input that is not requesting");

endmodule

// ==== hw/crossbar.sv ====
`timescale 1ns/1ps

module crossbar
  import nocPkg::*;
(
  input  portT grant     [numPorts],
  input  flitT headFlit  [numPorts],
  input  logic headValid [numPorts],
  input  logic outReady  [numPorts],
  output flitT outFlit   [numPorts],
  output logic outValid  [numPorts],
  output logic pop       [numPorts]
);

  // grant[o][i] means input i holds output o
  always_comb
  begin
    for (int o = 0; o < numPorts; o++)
    begin
      outFlit[o]  = '0;
      outValid[o] = 1'b0;
      for (int i = 0; i < numPorts; i++)
      begin
        if (grant[o][i])
        begin
          outFlit[o]  = headFlit[i];
          outValid[o] = headValid[i];
        end
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < numPorts; i++)
    begin
      pop[i] = 1'b0;
      for (int o = 0; o < numPorts; o++)
      begin
        if (grant[o][i] && outReady[o])
          pop[i] = headValid[i];
      end
    end
  end

endmodule

// ==== hw/meshRouter.sv ====
`timescale 1ns/1ps

module meshRouter
  import nocPkg::*;
#(
  parameter coordT localX    = 4'd0,
  parameter coordT localY    = 4'd0,
  parameter int    fifoDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  flitT inFlit   [numPorts],
  input  logic inValid  [numPorts],
  output logic inReady  [numPorts],
  output flitT outFlit  [numPorts],
  output logic outValid [numPorts],
  input  logic outReady [numPorts]
);

  flitT headFlit  [numPorts];
  logic headValid [numPorts];
  portT routeReq  [numPorts];
  portT arbReq    [numPorts];
  portT grant     [numPorts];
  logic pop       [numPorts];

  for (genvar i = 0; i < numPorts; i++)
  begin : gInput
    inputPort #(
      .localX    (localX),
      .localY    (localY),
      .fifoDepth (fifoDepth)
    ) uInputPort (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inFlit[i]),
      .inValid   (inValid[i]),
      .inReady   (inReady[i]),
      .pop       (pop[i]),
      .headFlit  (headFlit[i]),
      .headValid (headValid[i]),
      .routeReq  (routeReq[i])
    );
  end

  // Arbiter o sees bit o of every input's request
  for (genvar o = 0; o < numPorts; o++)
  begin : gOutput
    for (genvar i = 0; i < numPorts; i++)
    begin : gReq
      assign arbReq[o][i] = routeReq[i][o];
    end

    switchArbiter uArbiter (
      .clk      (clk),
      .rst      (rst),
      .req      (arbReq[o]),
      .headFlit (headFlit),
      .outReady (outReady[o]),
      .grant    (grant[o])
    );
  end

  crossbar uCrossbar (
    .grant     (grant),
    .headFlit  (headFlit),
    .headValid (headValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .pop       (pop)
  );

endmodule

// ==== sim/packetTable.svh ====
`ifndef PACKET_TABLE_SVH
`define PACKET_TABLE_SVH

// Columns: inPort, destX, destY, lenField, flits, group, expOut, order
// Ports are 0 Local, 1 North, 2 East, 3 West, 4 South. The router sits at (1, 1)
// order is the header's position among headers on its output in the group, -1 if free
localparam int numRows = 16;

localparam rowT rows [numRows] = '{
  // Group 0, one packet per direction, no back-pressure
  '{0, 2, 1, 3, 3, 0, 2, -1},
  '{1, 0, 1, 2, 2, 0, 3, -1},
  '{2, 1, 2, 4, 4, 0, 1, -1},
  '{3, 1, 0, 3, 3, 0, 4, -1},
  '{4, 1, 1, 2, 2, 0, 0, -1},
  // Group 1, random outReady on every output
  '{0, 1, 3, 5, 5, 1, 1, -1},
  '{2, 0, 2, 4, 4, 1, 3, -1},
  // Group 2, North and East both want South
  '{1, 1, 0, 4, 4, 2, 4, -1},
  '{2, 1, 0, 5, 5, 2, 4, -1},
  // Group 3, Local claims 3 flits but sends 6 while West waits
  '{0, 2, 2, 3, 6, 3, 2, 0},
  '{3, 3, 1, 5, 5, 3, 2, 1},
  // Group 4, North, East and South share West
  '{1, 0, 1, 3, 3, 4, 3, 0},
  '{2, 0, 1, 3, 3, 4, 3, 1},
  '{4, 0, 1, 3, 3, 4, 3, 2},
  '{1, 0, 1, 4, 4, 4, 3, 3},
  '{2, 0, 1, 2, 2, 4, 3, 4}
};

`endif

// ==== sim/meshRouterTb.sv ====
`timescale 1ns/1ps

module meshRouterTb
  import nocPkg::*;
;

  typedef struct packed {
    int inPort;
    int destX;
    int destY;
    int lenField;
    int flits;
    int group;
    int expOut;
    int order;
  } rowT;

  `include "packetTable.svh"

  localparam int numGroups = 5;

  logic clk;
  logic rst;
  flitT inFlit   [numPorts];
  logic inValid  [numPorts];
  logic inReady  [numPorts];
  flitT outFlit  [numPorts];
  logic outValid [numPorts];
  logic outReady [numPorts];

  logic        bpOn;
  logic [31:0] lcgState;
  flitT        expQ [numRows][$];
  int          pending;
  int          errors;
  int          testErrors;
  int          checks;
  int          hdrCount [numPorts];
  int          lastTag [numPorts];
  int          runLen [numRows];
  logic        firstRun [numRows];
  logic        stalled [numPorts];
  flitT        stallFlit [numPorts];
  string       testName [numGroups] = '{"routing", "back-pressure", "contention",
                                        "timer expiry", "round-robin"};

  meshRouter #(
    .localX    (4'd1),
    .localY    (4'd1),
    .fifoDepth (4)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Header carries the row index as srcTag, body words carry tag and flit number
  function automatic flitT makeFlit(int r, int k);
    flitT   f;
    headerT h;
    if (k == 0)
    begin
      h.reserved = 8'h00;
      h.srcTag   = 4'(r);
      h.destX    = 4'(rows[r].destX);
      h.destY    = 4'(rows[r].destY);
      h.length   = 12'(rows[r].lenField);
      f.id       = idHeader;
      f.data     = h;
    end
    else
    begin
      f.id   = (k == rows[r].flits - 1) ? idTail : idBody;
      f.data = {8'h00, 4'(r), 8'h00, 12'(k)};
    end
    return f;
  endfunction

  function automatic int totalFlits();
    int sum;
    sum = 0;
    for (int r = 0; r < numRows; r++)
      sum += rows[r].flits;
    return sum;
  endfunction

  task automatic checkVal(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
      testErrors++;
    end
  endtask

  task automatic reportError(string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
    testErrors++;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // outReady changes with the other inputs, 10 ns after the edge
  initial
  begin
    lcgState = 32'hb6b427d1;
    for (int o = 0; o < numPorts; o++)
      outReady[o] = 1'b1;
    forever
    begin
      @(posedge clk);
      #10;
      for (int o = 0; o < numPorts; o++)
      begin
        if (bpOn)
        begin
          lcgState = lcgNext(lcgState);
          outReady[o] = (lcgState[31:30] != 2'b00);
        end
        else
          outReady[o] = 1'b1;
      end
    end
  end

  task automatic driveInput(int p, int grp);
    logic accepted;
    for (int r = 0; r < numRows; r++)
    begin
      if (rows[r].group == grp && rows[r].inPort == p)
      begin
        for (int k = 0; k < rows[r].flits; k++)
        begin
          inFlit[p]  = makeFlit(r, k);
          inValid[p] = 1'b1;
          accepted   = 1'b0;
          while (!accepted)
          begin
            @(negedge clk);
            accepted = inReady[p];
          end
          @(posedge clk);
          #10;
        end
      end
    end
    inValid[p] = 1'b0;
    inFlit[p]  = '0;
  endtask

  task automatic observeOutputs();
    int   t;
    flitT f;
    for (int o = 0; o < numPorts; o++)
    begin
      if (stalled[o])
      begin
        checkVal($sformatf("outValid[%0d] under stall", o), 64'(outValid[o]), 64'd1);
        checkVal($sformatf("outFlit[%0d] under stall", o), 64'(outFlit[o]),
                 64'(stallFlit[o]));
      end
      stalled[o]   = outValid[o] && !outReady[o];
      stallFlit[o] = outFlit[o];
      if (outValid[o] && outReady[o])
      begin
        f = outFlit[o];
        t = int'(f.data[23:20]);
        if (expQ[t].size() == 0)
          reportError($sformatf("unexpected flit on output %0d with tag %0d", o, t));
        else
        begin
          checkVal($sformatf("outFlit[%0d]", o), 64'(f), 64'(expQ[t].pop_front()));
          checkVal($sformatf("output of tag %0d", t), 64'(o), 64'(rows[t].expOut));
          pending--;
        end
        if (lastTag[o] >= 0 && lastTag[o] != t)
          firstRun[lastTag[o]] = 1'b0;
        if (f.id == idHeader)
        begin
          if (rows[t].order >= 0)
            checkVal($sformatf("header order on output %0d", o), 64'(hdrCount[o]),
                     64'(rows[t].order));
          hdrCount[o]++;
          firstRun[t] = 1'b1;
          runLen[t]   = 0;
        end
        else if (rows[t].lenField == rows[t].flits)
          checkVal($sformatf("source tag on output %0d", o), 64'(t), 64'(lastTag[o]));
        if (firstRun[t])
        begin
          runLen[t]++;
          if (rows[t].lenField < rows[t].flits && runLen[t] > rows[t].lenField)
            reportError($sformatf("tag %0d kept output %0d past its length", t, o));
        end
        lastTag[o] = t;
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      observeOutputs();
  end

  initial
  begin
    longint limitNs;
    limitNs = longint'(totalFlits()) * 40 * 100;
    #(limitNs);
    $display("Watchdog expired with %0d flits still missing", pending);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    bpOn = 1'b0;
    errors = 0;
    checks = 0;
    pending = 0;
    testErrors = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]   = '0;
      inValid[p]  = 1'b0;
      stalled[p]  = 1'b0;
      stallFlit[p] = '0;
    end
    for (int c = 0; c < 7; c++)
    begin
      @(negedge clk);
      for (int p = 0; p < numPorts; p++)
      begin
        checkVal($sformatf("outValid[%0d] in reset", p), 64'(outValid[p]), 64'd0);
        checkVal($sformatf("inReady[%0d] in reset", p), 64'(inReady[p]), 64'd1);
      end
    end
    @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    for (int p = 0; p < numPorts; p++)
    begin
      checkVal($sformatf("outValid[%0d] after reset", p), 64'(outValid[p]), 64'd0);
      checkVal($sformatf("inReady[%0d] after reset", p), 64'(inReady[p]), 64'd1);
    end
    $display("Test reset state finished with %0d errors", testErrors);

    for (int g = 0; g < numGroups; g++)
    begin
      testErrors = 0;
      bpOn = (g != 0);
      for (int o = 0; o < numPorts; o++)
      begin
        hdrCount[o] = 0;
        lastTag[o]  = -1;
      end
      for (int r = 0; r < numRows; r++)
      begin
        firstRun[r] = 1'b0;
        runLen[r]   = 0;
        if (rows[r].group == g)
        begin
          for (int k = 0; k < rows[r].flits; k++)
            expQ[r].push_back(makeFlit(r, k));
          pending += rows[r].flits;
        end
      end
      @(posedge clk);
      #10;
      fork
        driveInput(0, g);
        driveInput(1, g);
        driveInput(2, g);
        driveInput(3, g);
        driveInput(4, g);
      join
      while (pending != 0)
        @(negedge clk);
      repeat (4) @(negedge clk);  // Lets stray flits show up before the next group
      $display("Test %s finished with %0d errors", testName[g], testErrors);
    end

    $display("Summary: %0d tests, %0d checks, %0d errors", numGroups + 1, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== meshRouter.f ====
+incdir+sim
common/nocPkg.sv
hw/inputPort/inputPort.sv
hw/switchArbiter/packetTimer.sv
hw/switchArbiter/switchArbiter.sv
hw/crossbar.sv
hw/meshRouter.sv
sim/meshRouterTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module meshRouterTb -f meshRouter.f -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
